/* run.sh */
#!/bin/sh
# Build the timer testbench with Verilator and run it
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module pit_tb -o pit_sim \
  && ./obj_dir/pit_sim > sim.log 2>&1
status=$?
[ -f sim.log ] && cat sim.log
[ -f sim.log ] || exit 1
grep -q "tests failed" sim.log && exit 1
[ "$status" -eq 0 ] || exit 1
exit 0

/* src.f */
verilog/pit_pkg.sv
verilog/pit_host_if.sv
verilog/pit_counter.sv
verilog/pit_readback.sv
verilog/pit_top.sv
tb/pit_checker.sv
tb/pit_tb.sv

/* tb/pit_checker.sv */
// Timer protocol assertions
`timescale 1ns/1ps
`default_nettype none

module pit_checker (
  input logic                           zclk,
  input logic                           load,
  input logic                           wr_stb,
  input logic                           rd_stb,
  input logic                           rd_valid,
  input logic [pit_pkg::pit_num_ch-1:0] out
);

  // Host issues one access per cycle
  a_strobe_excl: assert property (@(posedge zclk) disable iff (load) !(wr_stb && rd_stb))
    else $error("write and read strobes high in the same cycle");

  a_rd_valid: assert property (@(posedge zclk) disable iff (load) rd_valid == $past(rd_stb))
    else $error("rd_valid does not follow rd_stb by one cycle");

  a_out_reset: assert property (@(posedge zclk) load |-> (out == '0))
    else $error("out not low during reset");

endmodule

bind pit_top pit_checker u_chk (
  .zclk     (zclk),
  .load     (load),
  .wr_stb   (wr_stb),
  .rd_stb   (rd_stb),
  .rd_valid (rd_valid),
  .out      (out)
);

`default_nettype wire

/* tb/pit_tb.sv */
// Interval timer testbench
`timescale 1ns/1ps
`default_nettype none

module pit_tb;

  localparam int clk_period  = 20;
  localparam int gap_max     = 4;     // Longest tick spacing in cycles
  localparam int tick_budget = 320;   // Ticks over all tests

  logic               zclk;
  logic               load;
  logic               wr_stb;
  logic               rd_stb;
  pit_pkg::pit_addr_t addr;
  pit_pkg::pit_byte_t wr_data;
  pit_pkg::pit_byte_t rd_data;
  logic               rd_valid;
  logic [2:0]         tick;
  logic [2:0]         gate;
  logic [2:0]         out;

  // Reference model state per channel
  pit_pkg::pit_mode_e  m_mode  [3] = '{default: pit_pkg::mode_tc};
  pit_pkg::pit_rw_e    m_rw    [3] = '{default: pit_pkg::rw_latch};
  int                  m_n     [3] = '{default: 0};
  pit_pkg::pit_count_t m_cnt   [3] = '{default: '0};
  pit_pkg::pit_count_t m_latch [3] = '{default: '0};
  pit_pkg::pit_byte_t  m_lsb   [3] = '{default: '0};
  logic m_armed [3] = '{default: 1'b0};   // Load due on next enabled tick
  logic m_run   [3] = '{default: 1'b0};
  logic m_out   [3] = '{default: 1'b0};
  logic m_hi    [3] = '{default: 1'b1};
  logic m_pend  [3] = '{default: 1'b0};
  logic m_held  [3] = '{default: 1'b0};
  logic m_msb   [3] = '{default: 1'b0};
  pit_pkg::pit_byte_t m_rd = '0;
  logic m_rd_valid = 1'b0;

  int    test_err = 0;
  int    errors = 0;
  int    n_tests = 0;
  int    n_failed = 0;
  string test_name = "reset";

  pit_top dut (.*);

  initial begin
    zclk = 1'b0;
    forever #(clk_period / 2) zclk = !zclk;
  end

  initial begin
    #((tick_budget * gap_max + 600) * clk_period);
    $display("Watchdog expired while running %s", test_name);
    $display("tests failed");
    $finish;
  end

  task automatic check_out(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s %s expected %b actual %b", test_name, what, exp, act);
      test_err++;
    end
  endtask

  task automatic check_byte(input string what, input pit_pkg::pit_byte_t exp,
                            input pit_pkg::pit_byte_t act);
    if (act !== exp) begin
      $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
      test_err++;
    end
  endtask

  // Advances the model by one clock with the inputs now driven
  task automatic model_edge();
    int                  ch;
    int                  val;
    logic                done;
    pit_pkg::pit_count_t src;
    m_rd_valid = rd_stb;
    if (rd_stb) begin
      ch = int'(addr);
      m_rd = '0;                               // Control address
      if (ch < 3) begin
        src = m_held[ch] ? m_latch[ch] : m_cnt[ch];
        case (m_rw[ch])
          pit_pkg::rw_lsb:     m_rd = src[7:0];
          pit_pkg::rw_msb:     m_rd = src[15:8];
          pit_pkg::rw_lsb_msb: m_rd = m_msb[ch] ? src[15:8] : src[7:0];
          default:             m_rd = '0;
        endcase
        if (m_rw[ch] == pit_pkg::rw_lsb_msb) m_msb[ch] = !m_msb[ch];
        if (m_rw[ch] != pit_pkg::rw_lsb_msb || !m_msb[ch]) m_held[ch] = 1'b0;
      end
    end else if (wr_stb && addr == pit_pkg::pit_ctrl_addr) begin
      ch = int'(wr_data[7:6]);
      if (ch < 3 && wr_data[5:4] == 2'd0) begin
        if (!m_held[ch]) m_latch[ch] = m_cnt[ch];
        m_held[ch] = 1'b1;
      end else if (ch < 3 && (wr_data[3:1] inside {3'd0, 3'd2, 3'd3})) begin
        m_mode[ch]  = pit_pkg::pit_mode_e'(wr_data[3:1]);
        m_rw[ch]    = pit_pkg::pit_rw_e'(wr_data[5:4]);
        m_pend[ch]  = 1'b0;
        m_run[ch]   = 1'b0;
        m_armed[ch] = 1'b0;
        m_hi[ch]    = 1'b1;
        m_out[ch]   = (wr_data[3:1] != 3'd0);
        m_held[ch]  = 1'b0;
        m_msb[ch]   = 1'b0;
      end
    end else if (wr_stb) begin
      ch = int'(addr);
      done = 1'b0;
      val = 0;
      case (m_rw[ch])
        pit_pkg::rw_lsb: begin
          val = int'(wr_data);
          done = 1'b1;
        end
        pit_pkg::rw_msb: begin
          val = int'(wr_data) * 256;
          done = 1'b1;
        end
        pit_pkg::rw_lsb_msb: begin
          if (m_pend[ch]) begin
            val = int'({wr_data, m_lsb[ch]});
            done = 1'b1;
          end else begin
            m_lsb[ch] = wr_data;
          end
          m_pend[ch] = !m_pend[ch];
        end
        default: done = 1'b0;
      endcase
      if (done) begin
        m_n[ch] = (val == 0) ? 65536 : val;
        if (!m_run[ch] || m_mode[ch] == pit_pkg::mode_tc) m_armed[ch] = 1'b1;
      end
    end
    for (int i = 0; i < 3; i++) begin
      if (tick[i] && gate[i] && m_armed[i]) begin
        m_armed[i] = 1'b0;
        m_run[i] = 1'b1;
        m_hi[i] = 1'b1;
        if (m_mode[i] == pit_pkg::mode_square) m_cnt[i] = pit_pkg::pit_count_t'((m_n[i] + 1) / 2);
        else m_cnt[i] = pit_pkg::pit_count_t'(m_n[i]);
        if (m_mode[i] != pit_pkg::mode_tc) m_out[i] = 1'b1;
      end else if (tick[i] && gate[i] && m_run[i]) begin
        if (m_mode[i] == pit_pkg::mode_tc) begin
          m_cnt[i]--;
          if (m_cnt[i] == 0) m_out[i] = 1'b1;    // Terminal count
        end else if (m_mode[i] == pit_pkg::mode_rate) begin
          if (m_cnt[i] == 1) begin
            m_cnt[i] = pit_pkg::pit_count_t'(m_n[i]);
            m_out[i] = 1'b1;
          end else begin
            m_cnt[i]--;
            m_out[i] = (m_cnt[i] != 1);
          end
        end else if (m_cnt[i] != 1) begin
          m_cnt[i]--;
        end else if (m_hi[i] && m_n[i] / 2 > 0) begin
          m_hi[i] = 1'b0;
          m_cnt[i] = pit_pkg::pit_count_t'(m_n[i] / 2);
          m_out[i] = 1'b0;
        end else begin
          m_hi[i] = 1'b1;
          m_cnt[i] = pit_pkg::pit_count_t'((m_n[i] + 1) / 2);
          m_out[i] = 1'b1;
        end
      end
      if (m_mode[i] != pit_pkg::mode_tc && !gate[i]) begin
        m_out[i] = 1'b1;
        if (m_run[i]) m_armed[i] = 1'b1;   // Restart after gate rises
      end
    end
  endtask

  task automatic cycle();
    model_edge();
    @(posedge zclk);
    #2;
    for (int i = 0; i < 3; i++) check_out($sformatf("out%0d", i), m_out[i], out[i]);
    check_out("rd_valid", m_rd_valid, rd_valid);
    if (m_rd_valid) check_byte("rd_data", m_rd, rd_data);
    wr_stb = 1'b0;
    rd_stb = 1'b0;
    tick = '0;
  endtask

  task automatic host_write(input pit_pkg::pit_addr_t a, input pit_pkg::pit_byte_t d);
    wr_stb = 1'b1;
    addr = a;
    wr_data = d;
    cycle();
  endtask

  task automatic host_read(input pit_pkg::pit_addr_t a);
    rd_stb = 1'b1;
    addr = a;
    cycle();
  endtask

  task automatic setup_channel(input int ch, input pit_pkg::pit_mode_e md,
                               input pit_pkg::pit_rw_e rw, input int n);
    host_write(pit_pkg::pit_ctrl_addr, {2'(ch), rw, md, 1'b0});
    if (rw != pit_pkg::rw_msb) host_write(2'(ch), n[7:0]);
    if (rw != pit_pkg::rw_lsb) host_write(2'(ch), n[15:8]);
  endtask

  // Tick strobes 2 to gap_max cycles apart
  task automatic run_ticks(input int ch, input int cnt);
    repeat (cnt) begin
      repeat (1 + $urandom_range(gap_max - 2)) cycle();
      tick[ch] = 1'b1;
      cycle();
    end
  endtask

  task automatic end_test();
    n_tests++;
    errors += test_err;
    if (test_err != 0) n_failed++;
    $display("%s %s with %0d errors", (test_err == 0) ? "PASS" : "FAIL", test_name, test_err);
    test_err = 0;
  endtask

  initial begin
    int n;
    void'($urandom(32'h72a9_0510));
    load = 1'b1;
    wr_stb = 1'b0;
    rd_stb = 1'b0;
    addr = '0;
    wr_data = '0;
    tick = '0;
    gate = 3'b111;
    repeat (4) @(posedge zclk);
    #2;
    load = 1'b0;
    repeat (6) cycle();
    end_test();

    test_name = "terminal_count";
    n = 2 + $urandom_range(38);
    setup_channel(0, pit_pkg::mode_tc, pit_pkg::rw_lsb_msb, n);
    run_ticks(0, n + 4);
    check_out("out0 held after count 0", 1'b1, out[0]);
    end_test();

    test_name = "rate_generator";
    n = 2 + $urandom_range(10);
    setup_channel(1, pit_pkg::mode_rate, pit_pkg::rw_lsb, n);
    run_ticks(1, 4 * n + 1);
    end_test();

    test_name = "square_wave";
    setup_channel(2, pit_pkg::mode_square, pit_pkg::rw_lsb, 3 + 2 * $urandom_range(5));
    run_ticks(2, 40);
    setup_channel(2, pit_pkg::mode_square, pit_pkg::rw_lsb, 2 + 2 * $urandom_range(5));
    run_ticks(2, 40);
    end_test();

    test_name = "latch_readback";
    for (int r = 1; r < 4; r++) begin
      setup_channel(r - 1, pit_pkg::mode_tc, pit_pkg::pit_rw_e'(r), 300 + $urandom_range(3000));
      run_ticks(r - 1, 4);
      host_write(pit_pkg::pit_ctrl_addr, {2'(r - 1), 6'd0});   // Latch command
      run_ticks(r - 1, 3);
      repeat (2) host_read(2'(r - 1));
      run_ticks(r - 1, 2);
      repeat (2) host_read(2'(r - 1));
    end
    host_read(pit_pkg::pit_ctrl_addr);
    end_test();

    test_name = "gate";
    setup_channel(0, pit_pkg::mode_tc, pit_pkg::rw_lsb, 20);
    run_ticks(0, 2);
    gate[0] = 1'b0;
    run_ticks(0, 5);
    host_read(0);
    gate[0] = 1'b1;
    run_ticks(0, 3);
    setup_channel(1, pit_pkg::mode_square, pit_pkg::rw_lsb_msb, 6 + $urandom_range(6));
    run_ticks(1, 5);
    gate[1] = 1'b0;
    run_ticks(1, 6);
    gate[1] = 1'b1;
    run_ticks(1, 1);
    repeat (2) host_read(1);                  // Count just reloaded
    run_ticks(1, 7);
    n = 3 + $urandom_range(5);
    setup_channel(2, pit_pkg::mode_rate, pit_pkg::rw_lsb, n);
    run_ticks(2, n);                          // Out low at count 1
    gate[2] = 1'b0;
    run_ticks(2, 4);
    gate[2] = 1'b1;
    run_ticks(2, 1);
    host_read(2);
    run_ticks(2, 2 * n);
    end_test();

    $display("%0d tests run, %0d with errors, %0d errors in all", n_tests, n_failed, errors);
    if (n_failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/pit_counter.sv */
// Timer channel down counter
`timescale 1ns/1ps
`default_nettype none

module pit_counter (
  input  logic                zclk,
  input  logic                load,
  input  logic                tick,
  input  logic                gate,
  input  logic                mode_wr,
  input  pit_pkg::pit_mode_e  mode,
  input  logic                cnt_ld,
  input  pit_pkg::pit_count_t cnt_val,
  output pit_pkg::pit_count_t count,
  output logic                out
);

  pit_pkg::pit_count_t           reload_q;   // Last written count
  pit_pkg::pit_count_t           count_q;
  logic                          run_q;      // Past the first load
  logic                          ld_req;     // Load on next enabled tick
  logic                          half_hi;    // Square wave high half
  logic                          out_q;
  logic                          en;
  logic                          periodic;
  logic [pit_pkg::pit_count_w:0] n_ext;
  pit_pkg::pit_count_t           hi_len;
  pit_pkg::pit_count_t           lo_len;

  assign en       = tick && gate;
  assign periodic = (mode == pit_pkg::mode_rate) || (mode == pit_pkg::mode_square);

  // A written zero means 65536
  assign n_ext  = {(reload_q == '0), reload_q};
  assign hi_len = pit_pkg::pit_count_t'((n_ext + 1) >> 1);  // ceil(N/2)
  assign lo_len = pit_pkg::pit_count_t'(n_ext >> 1);        // floor(N/2)

  always_ff @(posedge zclk) begin
    if (cnt_ld) begin
      reload_q <= cnt_val;
    end
  end

  always_ff @(posedge zclk or posedge load) begin
    if (load) begin
      count_q <= '0;
      run_q   <= 1'b0;
      ld_req  <= 1'b0;
      half_hi <= 1'b1;
      out_q   <= 1'b0;
    end else if (mode_wr) begin
      run_q   <= 1'b0;           // Idle until a count arrives
      ld_req  <= 1'b0;
      half_hi <= 1'b1;
      out_q   <= (mode != pit_pkg::mode_tc);
    end else begin
      if (en && ld_req) begin
        ld_req  <= 1'b0;
        run_q   <= 1'b1;
        half_hi <= 1'b1;
        if (mode == pit_pkg::mode_square) begin
          count_q <= hi_len;
        end else begin
          count_q <= reload_q;
        end
        if (periodic) begin
          out_q <= 1'b1;
        end
      end else if (en && run_q) begin
        case (mode)
          pit_pkg::mode_tc: begin
            count_q <= count_q - 1'b1;   // Wraps and keeps going
            if (count_q == 1) begin
              out_q <= 1'b1;
            end
          end
          pit_pkg::mode_rate: begin
            if (count_q == 1) begin
              count_q <= reload_q;       // End of period
              out_q   <= 1'b1;
            end else begin
              count_q <= count_q - 1'b1;
              out_q   <= (count_q != 2); // Low for the tick at 1
            end
          end
          default: begin
            if (count_q != 1) begin
              count_q <= count_q - 1'b1;
            end else if (half_hi && (lo_len != '0)) begin
              count_q <= lo_len;
              half_hi <= 1'b0;
              out_q   <= 1'b0;
            end else begin
              // N of 1 has no low half and stays high
              count_q <= hi_len;
              half_hi <= 1'b1;
              out_q   <= 1'b1;
            end
          end
        endcase
      end

      // Gate low holds periodic modes high and restarts the period later
      if (periodic && !gate) begin
        out_q <= 1'b1;
        if (run_q) begin
          ld_req <= 1'b1;
        end
      end

      // Mode 0 reloads at once, periodic modes wait for their own reload
      if (cnt_ld && (!run_q || (mode == pit_pkg::mode_tc))) begin
        ld_req <= 1'b1;
      end
    end
  end

  assign count = count_q;
  assign out   = out_q;

endmodule

`default_nettype wire

/* verilog/pit_host_if.sv */
// Timer host write port
`timescale 1ns/1ps
`default_nettype none

module pit_host_if (
  input  logic                zclk,
  input  logic                load,
  input  logic                wr_stb,
  input  pit_pkg::pit_addr_t  addr,
  input  pit_pkg::pit_byte_t  wr_data,
  output logic                mode_wr   [pit_pkg::pit_num_ch],
  output pit_pkg::pit_mode_e  mode      [pit_pkg::pit_num_ch],
  output pit_pkg::pit_rw_e    rw        [pit_pkg::pit_num_ch],
  output logic                latch_cmd [pit_pkg::pit_num_ch],
  output logic                cnt_ld    [pit_pkg::pit_num_ch],
  output pit_pkg::pit_count_t cnt_val   [pit_pkg::pit_num_ch]
);

  logic               ctrl_wr;
  logic [1:0]         cw_sel;
  pit_pkg::pit_rw_e   cw_rw;
  logic [2:0]         cw_mode;
  logic               cw_mode_ok;

  assign ctrl_wr = wr_stb && (addr == pit_pkg::pit_ctrl_addr);
  assign cw_sel  = wr_data[pit_pkg::cw_sc_hi:pit_pkg::cw_sc_lo];
  assign cw_rw   = pit_pkg::pit_rw_e'(wr_data[pit_pkg::cw_rw_hi:pit_pkg::cw_rw_lo]);
  assign cw_mode = wr_data[pit_pkg::cw_m_hi:pit_pkg::cw_m_lo];

  // Modes 1, 4, 5, 6 and 7 make the whole control word a no-op
  always_comb begin
    case (cw_mode)
      pit_pkg::mode_tc,
      pit_pkg::mode_rate,
      pit_pkg::mode_square: cw_mode_ok = 1'b1;
      default:              cw_mode_ok = 1'b0;
    endcase
  end

  for (genvar i = 0; i < pit_pkg::pit_num_ch; i++) begin : g_ch
    logic                ctrl_hit;
    logic                data_wr;
    pit_pkg::pit_mode_e  mode_q;
    pit_pkg::pit_rw_e    rw_q;
    logic                lsb_pend;   // LSB written, MSB due next
    pit_pkg::pit_byte_t  lsb_q;
    logic                ld;
    pit_pkg::pit_count_t val;

    // Select value 3 never matches a channel
    assign ctrl_hit     = ctrl_wr && (cw_sel == 2'(i));
    assign latch_cmd[i] = ctrl_hit && (cw_rw == pit_pkg::rw_latch);
    assign mode_wr[i]   = ctrl_hit && (cw_rw != pit_pkg::rw_latch) && cw_mode_ok;
    assign data_wr      = wr_stb && (addr == 2'(i));

    // Counter sees the new mode in the strobe cycle itself
    assign mode[i] = mode_wr[i] ? pit_pkg::pit_mode_e'(cw_mode) : mode_q;
    assign rw[i]   = rw_q;

    always_ff @(posedge zclk or posedge load) begin
      if (load) begin
        mode_q   <= pit_pkg::mode_tc;
        rw_q     <= pit_pkg::rw_latch;
        lsb_pend <= 1'b0;
      end else if (mode_wr[i]) begin
        mode_q   <= pit_pkg::pit_mode_e'(cw_mode);
        rw_q     <= cw_rw;
        lsb_pend <= 1'b0;      // Byte sequence restarts
      end else if (data_wr && (rw_q == pit_pkg::rw_lsb_msb)) begin
        lsb_pend <= !lsb_pend;
      end
    end

    // Low byte held until the high byte arrives
    always_ff @(posedge zclk) begin
      if (data_wr && !lsb_pend) begin
        lsb_q <= wr_data;
      end
    end

    // Count assembly per rw mode
    always_comb begin
      ld  = 1'b0;
      val = {8'h00, wr_data};
      case (rw_q)
        pit_pkg::rw_lsb: begin
          ld = data_wr;
        end
        pit_pkg::rw_msb: begin
          ld  = data_wr;
          val = {wr_data, 8'h00};
        end
        pit_pkg::rw_lsb_msb: begin
          ld  = data_wr && lsb_pend;   // Complete on the second byte
          val = {wr_data, lsb_q};
        end
        default: begin
          ld = 1'b0;                   // Channel never programmed
        end
      endcase
    end

    assign cnt_ld[i]  = ld;
    assign cnt_val[i] = val;
  end

endmodule

`default_nettype wire

/* verilog/pit_pkg.sv */
// Interval timer shared definitions
`default_nettype none

package pit_pkg;

  localparam int pit_num_ch  = 3;   // Channels 0 to 2
  localparam int pit_count_w = 16;

  typedef logic [pit_count_w-1:0] pit_count_t;
  typedef logic [7:0]             pit_byte_t;
  typedef logic [1:0]             pit_addr_t;

  // Addresses 0 to 2 are the channel count registers
  localparam pit_addr_t pit_ctrl_addr = 2'd3;

  // Control word field positions
  localparam int cw_sc_hi = 7;    // Channel select
  localparam int cw_sc_lo = 6;
  localparam int cw_rw_hi = 5;    // Read/write mode
  localparam int cw_rw_lo = 4;
  localparam int cw_m_hi  = 3;    // Operating mode
  localparam int cw_m_lo  = 1;

  typedef enum logic [1:0] {
    rw_latch   = 2'd0,    // Counter latch command
    rw_lsb     = 2'd1,
    rw_msb     = 2'd2,
    rw_lsb_msb = 2'd3     // Low byte first
  } pit_rw_e;

  // Modes 1, 4 and 5 are not built
  typedef enum logic [2:0] {
    mode_tc     = 3'd0,   // Event at terminal count
    mode_rate   = 3'd2,   // Rate generator
    mode_square = 3'd3    // Square wave
  } pit_mode_e;

endpackage

`default_nettype wire

/* verilog/pit_readback.sv */
// Count latch and read-back
`timescale 1ns/1ps
`default_nettype none

module pit_readback (
  input  logic                zclk,
  input  logic                load,
  input  logic                rd_stb,
  input  pit_pkg::pit_addr_t  addr,
  input  logic                mode_wr   [pit_pkg::pit_num_ch],
  input  pit_pkg::pit_rw_e    rw        [pit_pkg::pit_num_ch],
  input  logic                latch_cmd [pit_pkg::pit_num_ch],
  input  pit_pkg::pit_count_t count     [pit_pkg::pit_num_ch],
  output pit_pkg::pit_byte_t  rd_data,
  output logic                rd_valid
);

  pit_pkg::pit_byte_t ch_byte [pit_pkg::pit_num_ch];  // Next byte per channel
  pit_pkg::pit_byte_t rd_byte;

  for (genvar i = 0; i < pit_pkg::pit_num_ch; i++) begin : g_ch
    pit_pkg::pit_count_t latch_q;
    pit_pkg::pit_count_t src;
    pit_pkg::pit_byte_t  byte_sel;
    logic                held;       // Latched count not yet read out
    logic                msb_next;   // High byte of a pair is due
    logic                rd_hit;
    logic                last_byte;

    assign rd_hit    = rd_stb && (addr == 2'(i));
    assign src       = held ? latch_q : count[i];
    assign last_byte = (rw[i] != pit_pkg::rw_lsb_msb) || msb_next;

    always_comb begin
      case (rw[i])
        pit_pkg::rw_lsb:     byte_sel = src[7:0];
        pit_pkg::rw_msb:     byte_sel = src[15:8];
        pit_pkg::rw_lsb_msb: byte_sel = msb_next ? src[15:8] : src[7:0];
        default:             byte_sel = '0;   // Unprogrammed channel
      endcase
    end

    assign ch_byte[i] = byte_sel;

    always_ff @(posedge zclk or posedge load) begin
      if (load) begin
        held     <= 1'b0;
        msb_next <= 1'b0;
      end else if (mode_wr[i]) begin
        held     <= 1'b0;
        msb_next <= 1'b0;
      end else if (latch_cmd[i]) begin
        held <= 1'b1;
      end else if (rd_hit) begin
        if (rw[i] == pit_pkg::rw_lsb_msb) begin
          msb_next <= !msb_next;
        end
        if (last_byte) begin
          held <= 1'b0;              // Release after final byte
        end
      end
    end

    // A second latch command is ignored while one is held
    always_ff @(posedge zclk) begin
      if (latch_cmd[i] && !held) begin
        latch_q <= count[i];
      end
    end
  end

  always_comb begin
    rd_byte = '0;                    // Control address reads as zero
    for (int k = 0; k < pit_pkg::pit_num_ch; k++) begin
      if (addr == 2'(k)) begin
        rd_byte = ch_byte[k];
      end
    end
  end

  always_ff @(posedge zclk or posedge load) begin
    if (load) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_stb;
    end
  end

  always_ff @(posedge zclk) begin
    if (rd_stb) begin
      rd_data <= rd_byte;
    end
  end

endmodule

`default_nettype wire

/* verilog/pit_top.sv */
// Three-channel interval timer
`timescale 1ns/1ps
`default_nettype none

module pit_top (
  input  logic                          zclk,
  input  logic                          load,
  input  logic                          wr_stb,
  input  pit_pkg::pit_addr_t            addr,
  input  pit_pkg::pit_byte_t            wr_data,
  input  logic                          rd_stb,
  input  logic [pit_pkg::pit_num_ch-1:0] tick,
  input  logic [pit_pkg::pit_num_ch-1:0] gate,
  output pit_pkg::pit_byte_t            rd_data,
  output logic                          rd_valid,
  output logic [pit_pkg::pit_num_ch-1:0] out
);

  logic                mode_wr   [pit_pkg::pit_num_ch];
  pit_pkg::pit_mode_e  mode      [pit_pkg::pit_num_ch];
  pit_pkg::pit_rw_e    rw        [pit_pkg::pit_num_ch];
  logic                latch_cmd [pit_pkg::pit_num_ch];
  logic                cnt_ld    [pit_pkg::pit_num_ch];
  pit_pkg::pit_count_t cnt_val   [pit_pkg::pit_num_ch];
  pit_pkg::pit_count_t count     [pit_pkg::pit_num_ch];   // Live counts

  pit_host_if u_host (
    .zclk      (zclk),
    .load      (load),
    .wr_stb    (wr_stb),
    .addr      (addr),
    .wr_data   (wr_data),
    .mode_wr   (mode_wr),
    .mode      (mode),
    .rw        (rw),
    .latch_cmd (latch_cmd),
    .cnt_ld    (cnt_ld),
    .cnt_val   (cnt_val)
  );

  for (genvar i = 0; i < pit_pkg::pit_num_ch; i++) begin : g_cnt
    pit_counter u_cnt (
      .zclk    (zclk),
      .load    (load),
      .tick    (tick[i]),
      .gate    (gate[i]),
      .mode_wr (mode_wr[i]),
      .mode    (mode[i]),
      .cnt_ld  (cnt_ld[i]),
      .cnt_val (cnt_val[i]),
      .count   (count[i]),
      .out     (out[i])
    );
  end

  pit_readback u_rdbk (
    .zclk      (zclk),
    .load      (load),
    .rd_stb    (rd_stb),
    .addr      (addr),
    .mode_wr   (mode_wr),
    .rw        (rw),
    .latch_cmd (latch_cmd),
    .count     (count),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid)
  );

endmodule

`default_nettype wire
